// ==== hw/icache_geom_pkg.sv ====
package icache_geom_pkg;

    // address split  tag | index | offset
    localparam int ADDR_W      = 32;
    localparam int INDEX_W     = 6;
    localparam int OFFSET_W    = 6;   // 64-byte lines
    localparam int TAG_W       = ADDR_W - INDEX_W - OFFSET_W; // 20

    localparam int LINE_W      = 512;
    localparam int FETCH_W     = 64;
    localparam int WORD_SEL_W  = 3;   // 8 words per line
    localparam int WORD_BYTE_W = OFFSET_W - WORD_SEL_W; // byte bits inside a word

    localparam int SET_NUM     = 1 << INDEX_W;
    localparam int NUM_WAYS    = 2;

    // burst counts on the memory port
    localparam logic [7:0] REFILL_LEN  = 8'd15;
    localparam logic [7:0] UNCACHE_LEN = 8'd1;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [LINE_W-1:0]   line_t;
    typedef logic [FETCH_W-1:0]  fetch_t;
    typedef logic [NUM_WAYS-1:0] way_mask_t; // one-hot way select

endpackage

// ==== hw/icache_ctrl_pkg.sv ====
package icache_ctrl_pkg;

    // main controller states
    typedef enum logic [2:0] {
        IDLE   = 3'd0,
        LOOKUP = 3'd1,
        MISS   = 3'd2,
        REFILL = 3'd3,
        CACOP  = 3'd4
    } ic_state_t;

    // cache operation codes as seen on i_cacop_code
    typedef enum logic [1:0] {
        STORE_TAG     = 2'd0,
        INDEX_INVALID = 2'd1,
        HIT_INVALID   = 2'd2,
        NONE          = 2'd3
    } cacop_t;

    typedef logic [6:0] exc_t;

    localparam exc_t EXC_NONE = 7'h00;
    localparam exc_t EXC_ADEF = 7'h08; // fetch address error

endpackage

// ==== hw/icache_array_if.sv ====
`timescale 1ns/1ps

interface icache_array_if import icache_geom_pkg::*; ();

    // controller side
    index_t    r_index;
    index_t    w_index;
    tag_t      w_tag;
    logic      tagv_clear;   // write invalid instead of tag
    way_mask_t way_we;
    line_t     refill_line;

    // one entry per way
    tag_t      tag_rdata  [NUM_WAYS];
    logic      valid      [NUM_WAYS];
    line_t     line_rdata [NUM_WAYS];

    modport ctrl (
        output r_index, w_index, w_tag, tagv_clear, way_we, refill_line,
        input  tag_rdata, valid, line_rdata
    );

    modport way (
        input  r_index, w_index, w_tag, tagv_clear, way_we, refill_line,
        output tag_rdata, valid, line_rdata
    );

endinterface

// ==== hw/icache_way.sv ====
`timescale 1ns/1ps

module icache_way import icache_geom_pkg::*; #(
    parameter int WAY_ID = 0
) (
    input  logic         clk,
    input  logic         rstn,
    icache_array_if.way  arr
);

    tag_t               tag_mem  [SET_NUM];
    line_t              line_mem [SET_NUM];
    logic [SET_NUM-1:0] valid_bits;

    tag_t  tag_q;
    logic  valid_q;
    line_t line_q;

    logic we;
    logic same_set;     // write and read hit the same set this cycle
    logic fill_data;

    assign we        = arr.way_we[WAY_ID];
    assign same_set  = we && (arr.w_index == arr.r_index);
    assign fill_data = we && !arr.tagv_clear;

    // valid bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_bits <= '0;
            valid_q    <= 1'b0;
        end else begin
            if (we) begin
                valid_bits[arr.w_index] <= !arr.tagv_clear;
            end
            if (same_set) begin
                valid_q <= !arr.tagv_clear;   // write-first
            end else begin
                valid_q <= valid_bits[arr.r_index];
            end
        end
    end

    // tag and line storage, synchronous read
    always_ff @(posedge clk) begin
        if (fill_data) begin
            tag_mem[arr.w_index]  <= arr.w_tag;
            line_mem[arr.w_index] <= arr.refill_line;
        end
        if (same_set && fill_data) begin
            tag_q  <= arr.w_tag;
            line_q <= arr.refill_line;
        end else begin
            tag_q  <= tag_mem[arr.r_index];
            line_q <= line_mem[arr.r_index];
        end
    end

    // on a clear the stale tag is masked by valid_q
    assign arr.tag_rdata[WAY_ID]  = tag_q;
    assign arr.valid[WAY_ID]      = valid_q;
    assign arr.line_rdata[WAY_ID] = line_q;

endmodule

// ==== hw/icache_lru.sv ====
`timescale 1ns/1ps

module icache_lru import icache_geom_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  index_t    i_index,
    input  logic      i_update,
    input  logic      i_used_way,
    output way_mask_t o_victim_way
);

    // way touched last, one bit per set
    logic [SET_NUM-1:0] mru;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mru <= '0;
        end else if (i_update) begin
            mru[i_index] <= i_used_way;
        end
    end

    // evict the way not used last
    always_comb begin
        if (mru[i_index]) begin
            o_victim_way = way_mask_t'(1);   // way 0
        end else begin
            o_victim_way = way_mask_t'(2);   // way 1
        end
    end

endmodule

// ==== hw/icache_ctrl.sv ====
`timescale 1ns/1ps

module icache_ctrl import icache_geom_pkg::*, icache_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         rstn,
    // fetch port
    input  logic         i_rvalid,
    input  addr_t        i_raddr,
    input  logic         i_uncache,
    output logic         o_rready,
    output fetch_t       o_rdata,
    output exc_t         o_exception,
    output addr_t        o_badv,
    output logic         o_idle,
    // memory port
    output logic         o_mem_rvalid,
    output addr_t        o_mem_raddr,
    output logic [7:0]   o_mem_rlen,
    input  logic         i_mem_rready,
    input  line_t        i_mem_rdata,
    // cache operations
    input  logic         i_cacop_en,
    input  cacop_t       i_cacop_code,
    output logic         o_cacop_ready,
    output logic         o_cacop_done,
    // ways and replacement
    icache_array_if.ctrl arr,
    output index_t       o_lru_index,
    output logic         o_lru_update,
    output logic         o_lru_used_way,
    input  way_mask_t    i_lru_victim
);

    ic_state_t state;
    ic_state_t next_state;
    ic_state_t accept_state;

    // request buffers
    addr_t  req_addr;
    logic   req_uncache;
    logic   req_cacop_en;
    cacop_t req_cacop;
    line_t  refill_buf;

    index_t                req_index;
    tag_t                  req_tag;
    logic [WORD_SEL_W-1:0] req_word;

    way_mask_t hit;
    logic      any_hit;
    logic      adef;
    logic      lookup_hit;
    logic      accept;
    logic      fill;        // refill writes the victim way
    way_mask_t cacop_way;
    line_t     src_line;

    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_tag   = req_addr[ADDR_W-1 -: TAG_W];
    assign req_word  = req_addr[OFFSET_W-1 -: WORD_SEL_W];

    // compare against tags read in the accept cycle
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit[w] = arr.valid[w] && (arr.tag_rdata[w] == req_tag);
        end
    end

    assign any_hit    = |hit;
    assign adef       = (req_addr[1:0] != 2'b00) && !req_cacop_en;
    assign lookup_hit = (state == LOOKUP) && !adef && !req_uncache && any_hit;
    assign accept     = ((state == IDLE) || lookup_hit || (state == REFILL)) &&
                        (i_rvalid || i_cacop_en);
    assign fill       = (state == REFILL) && !req_uncache && !req_cacop_en;
    assign accept_state = i_cacop_en ? CACOP : LOOKUP;  // cacop wins over fetch

    always_ff @(posedge clk) begin
        if (!rstn) begin
            req_uncache  <= 1'b0;
            req_cacop_en <= 1'b0;
            req_cacop    <= NONE;
        end else if (accept) begin
            req_uncache  <= i_uncache && !i_cacop_en;
            req_cacop_en <= i_cacop_en;
            req_cacop    <= i_cacop_code;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= i_raddr;
        end
        if ((state == MISS) && i_mem_rready) begin
            refill_buf <= i_mem_rdata;   // whole line in one beat
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE, REFILL: begin
                next_state = accept ? accept_state : IDLE;
            end
            LOOKUP: begin
                if (adef) begin
                    next_state = IDLE;
                end else if (req_uncache || !any_hit) begin
                    next_state = MISS;
                end else begin
                    next_state = accept ? accept_state : IDLE;
                end
            end
            MISS: begin
                if (i_mem_rready) begin
                    next_state = REFILL;
                end
            end
            CACOP:   next_state = REFILL;
            default: next_state = IDLE;
        endcase
    end

    // response
    assign o_idle      = (state == IDLE);
    assign o_rready    = ((state == LOOKUP) && (adef || lookup_hit)) ||
                         ((state == REFILL) && !req_cacop_en);
    assign o_exception = ((state == LOOKUP) && adef) ? EXC_ADEF : EXC_NONE;
    assign o_badv      = ((state == LOOKUP) && adef) ? req_addr : '0;

    assign src_line = (state == REFILL) ? refill_buf : arr.line_rdata[hit[1]];
    assign o_rdata  = req_uncache ? refill_buf[LINE_W-1 -: FETCH_W]
                                  : src_line[req_word*FETCH_W +: FETCH_W];

    // memory request held through MISS
    assign o_mem_rvalid = (state == MISS);
    assign o_mem_raddr  = req_uncache ? {req_addr[ADDR_W-1:WORD_BYTE_W], {WORD_BYTE_W{1'b0}}}
                                      : {req_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign o_mem_rlen   = req_uncache ? UNCACHE_LEN : REFILL_LEN;

    // cache operations
    assign o_cacop_ready = accept && i_cacop_en;
    assign o_cacop_done  = (state == REFILL) && req_cacop_en;

    always_comb begin
        case (req_cacop)
            STORE_TAG, INDEX_INVALID: cacop_way = way_mask_t'(1) << req_addr[0];
            HIT_INVALID:              cacop_way = hit;  // zero on a miss
            default:                  cacop_way = '0;
        endcase
    end

    // array control
    assign arr.r_index     = accept ? i_raddr[OFFSET_W +: INDEX_W] : req_index;
    assign arr.w_index     = req_index;
    assign arr.w_tag       = req_tag;
    assign arr.refill_line = refill_buf;
    assign arr.tagv_clear  = (state == CACOP);

    always_comb begin
        if (fill) begin
            arr.way_we = i_lru_victim;
        end else if (state == CACOP) begin
            arr.way_we = cacop_way;
        end else begin
            arr.way_we = '0;
        end
    end

    // replacement bookkeeping
    assign o_lru_index    = req_index;
    assign o_lru_update   = lookup_hit || fill;
    assign o_lru_used_way = fill ? i_lru_victim[1] : hit[1];

endmodule

// ==== hw/icache_top.sv ====
`timescale 1ns/1ps

module icache_top import icache_geom_pkg::*, icache_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    // fetch port
    input  logic       i_rvalid,
    input  addr_t      i_raddr,
    input  logic       i_uncache,
    output logic       o_rready,
    output fetch_t     o_rdata,
    output exc_t       o_exception,
    output addr_t      o_badv,
    output logic       o_idle,
    // memory port
    output logic       o_mem_rvalid,
    output addr_t      o_mem_raddr,
    output logic [7:0] o_mem_rlen,
    input  logic       i_mem_rready,
    input  line_t      i_mem_rdata,
    // cache operations
    input  logic       i_cacop_en,
    input  cacop_t     i_cacop_code,
    output logic       o_cacop_ready,
    output logic       o_cacop_done
);

    icache_array_if arr ();

    index_t    lru_index;
    logic      lru_update;
    logic      lru_used_way;
    way_mask_t lru_victim;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .i_rvalid       (i_rvalid),
        .i_raddr        (i_raddr),
        .i_uncache      (i_uncache),
        .o_rready       (o_rready),
        .o_rdata        (o_rdata),
        .o_exception    (o_exception),
        .o_badv         (o_badv),
        .o_idle         (o_idle),
        .o_mem_rvalid   (o_mem_rvalid),
        .o_mem_raddr    (o_mem_raddr),
        .o_mem_rlen     (o_mem_rlen),
        .i_mem_rready   (i_mem_rready),
        .i_mem_rdata    (i_mem_rdata),
        .i_cacop_en     (i_cacop_en),
        .i_cacop_code   (i_cacop_code),
        .o_cacop_ready  (o_cacop_ready),
        .o_cacop_done   (o_cacop_done),
        .arr            (arr.ctrl),
        .o_lru_index    (lru_index),
        .o_lru_update   (lru_update),
        .o_lru_used_way (lru_used_way),
        .i_lru_victim   (lru_victim)
    );

    icache_way #(.WAY_ID(0)) u_way0 (
        .clk  (clk),
        .rstn (rstn),
        .arr  (arr.way)
    );

    icache_way #(.WAY_ID(1)) u_way1 (
        .clk  (clk),
        .rstn (rstn),
        .arr  (arr.way)
    );

    icache_lru u_lru (
        .clk          (clk),
        .rstn         (rstn),
        .i_index      (lru_index),
        .i_update     (lru_update),
        .i_used_way   (lru_used_way),
        .o_victim_way (lru_victim)
    );

endmodule

// ==== test/tb_icache_model.svh ====
`ifndef TB_ICACHE_MODEL_SVH
`define TB_ICACHE_MODEL_SVH

// per-set model state, two ways
tag_t m_tag   [SET_NUM][NUM_WAYS];
bit   m_valid [SET_NUM][NUM_WAYS];
bit   m_mru   [SET_NUM];

// word k of the line that memory returns for address a
function automatic fetch_t line_word(input addr_t a, input int k);
    return {a ^ 32'hc3a5_0f1e, ~a + (32'(k) * 32'h9e37_79b9)};
endfunction

function automatic void model_reset();
    for (int s = 0; s < SET_NUM; s++) begin
        m_valid[s][0] = 1'b0;
        m_valid[s][1] = 1'b0;
        m_mru[s]      = 1'b0;
    end
endfunction

// predicts one aligned fetch and updates tag, valid and LRU state
function automatic void model_fetch(input addr_t a, input bit unc,
                                    output bit hit, output fetch_t data);
    index_t s;
    tag_t   t;
    int     w;
    s   = a[OFFSET_W +: INDEX_W];
    t   = a[ADDR_W-1 -: TAG_W];
    hit = 1'b0;
    if (unc) begin
        data = line_word({a[31:3], 3'b000}, 7);   // top word of the burst
        return;
    end
    data = line_word({a[31:6], 6'd0}, int'(a[5:3]));
    for (w = 0; w < NUM_WAYS; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == t) begin
            hit      = 1'b1;
            m_mru[s] = w[0];
        end
    end
    if (!hit) begin
        w            = m_mru[s] ? 0 : 1;   // evict the older way
        m_tag[s][w]  = t;
        m_valid[s][w] = 1'b1;
        m_mru[s]     = w[0];
    end
endfunction

function automatic void model_cacop(input addr_t a, input cacop_t code);
    index_t s;
    s = a[OFFSET_W +: INDEX_W];
    case (code)
        STORE_TAG, INDEX_INVALID: m_valid[s][a[0]] = 1'b0;
        HIT_INVALID: begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (m_valid[s][w] && m_tag[s][w] == a[ADDR_W-1 -: TAG_W]) begin
                    m_valid[s][w] = 1'b0;
                end
            end
        end
        default: ;
    endcase
endfunction

task automatic report_mismatch(input string what, input string exp_s, input string act_s);
    $display("** Error %s: expected %s actual %s", what, exp_s, act_s);
    $display("Testbench failed");
    $fatal(1, "stopping at first mismatch");
endtask

task automatic check_fetch(input string what, input fetch_t exp, input fetch_t act);
    if (exp !== act) report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_exc(input string what, input exc_t exp, input exc_t act);
    if (exp !== act) report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (exp !== act) report_mismatch(what, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_miss(input string what, input bit exp, input bit act);
    if (exp !== act) report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic check_len(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (exp !== act) report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

task automatic check_cycles(input string what, input int exp, input int act);
    if (exp != act) report_mismatch(what, $sformatf("%0d", exp), $sformatf("%0d", act));
endtask

`endif

// ==== test/tb_icache.sv ====
`timescale 1ns/1ps

module tb_icache import icache_geom_pkg::*, icache_ctrl_pkg::*; ();

    localparam int N_RAND    = 60;
    localparam int N_EVICT   = 8;
    localparam int N_UNC     = 18;
    localparam int N_ADEF    = 4;
    localparam int N_CACOP   = 12;   // each also runs two fetches
    localparam int N_B2B     = 40;
    localparam int MAX_DELAY = 5;
    localparam int N_TOTAL   = N_RAND + N_EVICT + N_UNC + N_ADEF + N_CACOP * 3 + N_B2B;

    logic       clk = 1'b0;
    logic       rstn;
    logic       i_rvalid;
    addr_t      i_raddr;
    logic       i_uncache;
    logic       o_rready;
    fetch_t     o_rdata;
    exc_t       o_exception;
    addr_t      o_badv;
    logic       o_idle;
    logic       o_mem_rvalid;
    addr_t      o_mem_raddr;
    logic [7:0] o_mem_rlen;
    logic       i_mem_rready;
    line_t      i_mem_rdata;
    logic       i_cacop_en;
    cacop_t     i_cacop_code;
    logic       o_cacop_ready;
    logic       o_cacop_done;

    logic [31:0] stim_lfsr = 32'h9ec0237d;
    logic [31:0] mem_lfsr  = 32'h9ec0237d;
    string       test_name;
    addr_t       req_a [$];
    bit          req_u [$];

    `include "tb_icache_model.svh"

    always #5 clk = ~clk;

    icache_top dut (.*);

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] draw(inout logic [31:0] s, input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = s[31] ^ s[21] ^ s[1] ^ s[0];
            s  = {s[30:0], fb};
            v  = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic addr_t pool_addr();
        tag_t   tags [4] = '{20'h1a2b3, 20'h0c4d5, 20'h7e6f1, 20'h35a90};
        index_t sets [4] = '{6'd0, 6'd13, 6'd42, 6'd63};
        addr_t  a;
        a = {tags[2'(draw(stim_lfsr, 2))], sets[2'(draw(stim_lfsr, 2))], 6'd0};
        a[5:2] = 4'(draw(stim_lfsr, 4));   // word and half-word position
        return a;
    endfunction

    // memory responder, random 0..5 cycle delay then one-beat line
    initial begin
        int dly;
        dly = 0;
        forever begin
            @(posedge clk);
            if (i_mem_rready) begin
                i_mem_rready <= 1'b0;
                dly = int'(draw(mem_lfsr, 3)) % (MAX_DELAY + 1);
            end else if (o_mem_rvalid) begin
                if (dly == 0) begin
                    for (int k = 0; k < 8; k++) begin
                        i_mem_rdata[k*64 +: 64] <= line_word(o_mem_raddr, k);
                    end
                    i_mem_rready <= 1'b1;
                end else begin
                    dly--;
                end
            end
        end
    end

    initial begin
        repeat (N_TOTAL * (MAX_DELAY + 10) + 20) @(posedge clk);
        $display("timeout: the DUT stopped answering requests");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    // runs the queued fetches, hold keeps i_rvalid high for back-to-back issue
    task automatic run_queue(input bit hold);
        int     total;
        int     issued;
        int     done;
        int     cyc;
        int     acc_cyc [$];
        bit     seen_mem;
        addr_t  mem_addr;
        logic [7:0] mem_len;
        bit     exp_hit;
        fetch_t exp_data;
        addr_t  a;
        string  nm;
        total    = req_a.size();
        issued   = 0;
        done     = 0;
        cyc      = 0;
        seen_mem = 1'b0;
        while (done < total) begin
            @(posedge clk);
            cyc++;
            if (i_rvalid && (o_idle || (o_rready && o_exception == EXC_NONE))) begin
                acc_cyc.push_back(cyc);
                issued++;
                i_rvalid <= 1'b0;
            end
            if (o_mem_rvalid) begin
                seen_mem = 1'b1;
                mem_addr = o_mem_raddr;
                mem_len  = o_mem_rlen;
            end
            if (o_rready) begin
                a  = req_a[done];
                nm = $sformatf("%s req %0d addr %h", test_name, done, a);
                if (a[1:0] != 2'b00) begin
                    check_exc({nm, " exc"}, EXC_ADEF, o_exception);
                    check_addr({nm, " badv"}, a, o_badv);
                    check_miss({nm, " mem access"}, 1'b0, seen_mem);
                end else begin
                    model_fetch(a, req_u[done], exp_hit, exp_data);
                    check_exc({nm, " exc"}, EXC_NONE, o_exception);
                    check_fetch({nm, " data"}, exp_data, o_rdata);
                    check_miss({nm, " miss"}, !exp_hit, seen_mem);
                    if (seen_mem && req_u[done]) begin
                        check_addr({nm, " mem addr"}, {a[31:3], 3'b000}, mem_addr);
                        check_len({nm, " mem len"}, UNCACHE_LEN, mem_len);
                    end else if (seen_mem) begin
                        check_addr({nm, " mem addr"}, {a[31:6], 6'd0}, mem_addr);
                        check_len({nm, " mem len"}, REFILL_LEN, mem_len);
                    end else begin
                        check_cycles({nm, " hit latency"}, 1, cyc - acc_cyc[done]);
                    end
                end
                done++;
                seen_mem = 1'b0;
            end
            if (issued < total && (hold || issued == done)) begin
                i_rvalid  <= 1'b1;
                i_raddr   <= req_a[issued];
                i_uncache <= req_u[issued];
            end
        end
        req_a.delete();
        req_u.delete();
    endtask

    task automatic do_cacop(input addr_t a, input cacop_t code);
        int cyc;
        int rdy_cyc;
        bit got;
        cyc = 0;
        got = 1'b0;
        @(posedge clk);
        i_cacop_en   <= 1'b1;
        i_cacop_code <= code;
        i_raddr      <= a;
        while (1) begin
            @(posedge clk);
            cyc++;
            if (!got && o_cacop_ready) begin
                got     = 1'b1;
                rdy_cyc = cyc;
                i_cacop_en <= 1'b0;
            end else if (got && o_cacop_done) begin
                break;
            end
        end
        check_cycles($sformatf("cacop %s addr %h done", code.name(), a), 2, cyc - rdy_cyc);
        model_cacop(a, code);
    endtask

    initial begin
        addr_t  a;
        tag_t   et [3];
        int     ord [N_EVICT];
        cacop_t code;
        rstn         = 1'b0;
        i_rvalid     = 1'b0;
        i_raddr      = '0;
        i_uncache    = 1'b0;
        i_mem_rready = 1'b0;
        i_mem_rdata  = '0;
        i_cacop_en   = 1'b0;
        i_cacop_code = NONE;
        model_reset();
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        check_miss("reset idle", 1'b1, o_idle);
        check_miss("reset rready", 1'b0, o_rready);
        check_miss("reset mem rvalid", 1'b0, o_mem_rvalid);
        check_miss("reset cacop ready", 1'b0, o_cacop_ready || o_cacop_done);

        test_name = "random";
        for (int j = 0; j < N_RAND; j++) begin
            a = pool_addr();
            if (draw(stim_lfsr, 4) == 0) a[1:0] = 2'b10;   // occasional misaligned fetch
            req_a.push_back(a);
            req_u.push_back(draw(stim_lfsr, 3) == 0);
        end
        run_queue(1'b0);

        // three tags in one set, order t0 t1 t0 t2 t1 t0 t2 t1
        test_name = "evict";
        et  = '{20'h11111, 20'h22222, 20'h33333};
        ord = '{0, 1, 0, 2, 1, 0, 2, 1};
        for (int j = 0; j < N_EVICT; j++) begin
            req_a.push_back({et[ord[j]], 6'd21, 3'(j), 3'b000});
            req_u.push_back(1'b0);
        end
        run_queue(1'b0);

        test_name = "uncached";
        for (int j = 0; j < N_UNC / 3; j++) begin
            a = pool_addr();
            a[1:0] = 2'b00;
            req_a.push_back(a);
            req_u.push_back(1'b1);
            repeat (2) begin
                req_a.push_back(a);
                req_u.push_back(1'b0);
            end
        end
        run_queue(1'b0);

        test_name = "adef";
        for (int j = 0; j < N_ADEF; j++) begin
            a = pool_addr();
            a[1:0] = 2'(j % 3 + 1);
            req_a.push_back(a);
            req_u.push_back(1'b0);
        end
        run_queue(1'b0);

        test_name = "cacop";
        for (int j = 0; j < N_CACOP; j++) begin
            a = pool_addr();
            a[1:0] = 2'b00;
            req_a.push_back(a);
            req_u.push_back(1'b0);
            run_queue(1'b0);
            code = cacop_t'(2'(draw(stim_lfsr, 2)));
            do_cacop({a[31:1], draw(stim_lfsr, 1) == 1}, code);
            req_a.push_back(a);
            req_u.push_back(1'b0);
            run_queue(1'b0);
        end

        test_name = "back-to-back";
        for (int j = 0; j < N_B2B; j++) begin
            a = pool_addr();
            a[1:0] = 2'b00;
            req_a.push_back(a);
            req_u.push_back(draw(stim_lfsr, 3) == 0);
        end
        run_queue(1'b1);

        repeat (2) @(posedge clk);
        if (o_idle === 1'b1) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("DUT did not return to idle at the end");
            $display("Testbench failed");
            $fatal(1, "not idle");
        end
    end

endmodule

// ==== icache.f ====
hw/icache_geom_pkg.sv
hw/icache_ctrl_pkg.sv
hw/icache_array_if.sv
hw/icache_way.sv
hw/icache_lru.sv
hw/icache_ctrl.sv
hw/icache_top.sv
+incdir+test
test/tb_icache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f icache.f --top-module tb_icache -Mdir obj_dir \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_icache > sim.log 2>&1 \
    && ! grep -q "Testbench failed" sim.log \
    && grep -q "Testbench passed" sim.log \
    && echo "simulation ok" \
    || { echo "simulation FAILED, see build.log and sim.log"; exit 1; }
